/* src/fp_ctrl_pkg.sv */
package fp_ctrl_pkg;

  // rounding mode, as driven on the mode port
  typedef logic [1:0] round_mode_t;

  localparam round_mode_t rm_zero  = 2'd0;
  localparam round_mode_t rm_even  = 2'd1;
  localparam round_mode_t rm_plus  = 2'd2;
  localparam round_mode_t rm_minus = 2'd3;

  // exception flags reported with each result
  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

  // quiet NaN returned for every NaN result
  localparam logic [31:0] canonical_nan = 32'h7fc00000;

endpackage

/* src/fp_format_pkg.sv */
package fp_format_pkg;
  import fp_ctrl_pkg::*;

  localparam int exp_w = 8;
  localparam int man_w = 23;
  localparam int bias  = 127;

  typedef logic [exp_w-1:0]        fp_exp_t;
  typedef logic [man_w:0]          fp_sig_t;
  typedef logic [2*man_w+1:0]      fp_prod_t;
  // two extra bits for overflow and underflow
  typedef logic signed [exp_w+1:0] fp_exp_sum_t;

  typedef struct packed {
    logic             sign;
    fp_exp_t          exp;
    logic [man_w-1:0] frac;
  } fp_word_t;

  // stage one to stage two
  typedef struct packed {
    logic        sign;
    fp_exp_sum_t exp_sum;
    fp_sig_t     sig_a;
    fp_sig_t     sig_b;
    logic        is_special;
    fp_word_t    special_result;
    logic        special_invalid;
    round_mode_t mode;
  } classified_t;

  // stage two to stage three
  typedef struct packed {
    logic        sign;
    fp_exp_sum_t exp_sum;
    fp_prod_t    prod;
    logic        is_special;
    fp_word_t    special_result;
    logic        special_invalid;
    round_mode_t mode;
  } product_t;

endpackage

/* src/fp_operand_classify.sv */
`timescale 1ns/1ns

module fp_operand_classify
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  fp_word_t    a,
  input  fp_word_t    b,
  input  round_mode_t mode,
  output logic        cls_valid,
  output classified_t cls
);

  logic        zero_a, zero_b;
  logic        inf_a, inf_b;
  logic        qnan_a, qnan_b;
  logic        snan_a, snan_b;
  logic        sign, invalid;
  classified_t cls_d;

  // zero exponent covers subnormals too since they read as zero
  assign zero_a = (a.exp == '0);
  assign zero_b = (b.exp == '0);
  assign inf_a  = (&a.exp) && (a.frac == '0);
  assign inf_b  = (&b.exp) && (b.frac == '0);
  assign qnan_a = (&a.exp) && a.frac[man_w-1];
  assign qnan_b = (&b.exp) && b.frac[man_w-1];
  assign snan_a = (&a.exp) && !a.frac[man_w-1] && (a.frac != '0);
  assign snan_b = (&b.exp) && !b.frac[man_w-1] && (b.frac != '0);

  assign sign    = a.sign ^ b.sign;
  assign invalid = snan_a || snan_b || (inf_a && zero_b) || (zero_a && inf_b);

  always_comb begin
    cls_d.sign       = sign;
    cls_d.exp_sum    = {2'b00, a.exp} + {2'b00, b.exp} - 10'(bias);
    cls_d.sig_a      = {1'b1, a.frac};
    cls_d.sig_b      = {1'b1, b.frac};
    cls_d.is_special = zero_a || zero_b || (&a.exp) || (&b.exp);
    cls_d.mode       = mode;
    cls_d.special_invalid = invalid;
    // nan outranks infinity which outranks zero
    if (invalid || qnan_a || qnan_b)
      cls_d.special_result = canonical_nan;
    else if (inf_a || inf_b)
      cls_d.special_result = {sign, {exp_w{1'b1}}, {man_w{1'b0}}};
    else
      cls_d.special_result = {sign, {exp_w{1'b0}}, {man_w{1'b0}}};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cls_valid <= 1'b0;
    end else begin
      cls_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      cls <= cls_d;
    end
  end

  // an all-ones exponent must give an infinity or NaN special result
  a_all_ones_special: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && ((&a.exp) || (&b.exp))
    |=> cls_valid && cls.is_special && (&cls.special_result.exp));

endmodule

/* src/fp_mant_multiply.sv */
`timescale 1ns/1ns

module fp_mant_multiply
  import fp_format_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cls_valid,
  input  classified_t cls,
  output logic        prod_valid,
  output product_t    prod
);

  product_t prod_d;

  // full 24x24 product with rounding left to the next stage
  always_comb begin
    prod_d.sign            = cls.sign;
    prod_d.exp_sum         = cls.exp_sum;
    prod_d.prod            = cls.sig_a * cls.sig_b;
    prod_d.is_special      = cls.is_special;
    prod_d.special_result  = cls.special_result;
    prod_d.special_invalid = cls.special_invalid;
    prod_d.mode            = cls.mode;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= cls_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cls_valid) begin
      prod <= prod_d;
    end
  end

endmodule

/* src/fp_round_pack.sv */
`timescale 1ns/1ns

module fp_round_pack
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      prod_valid,
  input  product_t  prod,
  output logic      out_valid,
  output fp_word_t  result,
  output fp_flags_t flags
);

  logic             norm_hi;
  fp_sig_t          sig_n;
  logic             guard;
  logic             sticky;
  logic             lsb;
  logic             round_up;
  logic [man_w+1:0] sig_r;
  logic             carry;
  logic [man_w-1:0] frac_r;
  fp_exp_sum_t      exp_n;
  fp_exp_sum_t      exp_r;
  logic             ovf;
  logic             unf;
  logic             ovf_to_inf;
  fp_word_t         result_d;
  fp_flags_t        flags_d;

  // product lies in [1,4) and bit 47 marks [2,4)
  assign norm_hi = prod.prod[47];
  assign sig_n   = norm_hi ? prod.prod[47:24] : prod.prod[46:23];
  assign guard   = norm_hi ? prod.prod[23] : prod.prod[22];
  assign sticky  = norm_hi ? |prod.prod[22:0] : |prod.prod[21:0];
  assign lsb     = sig_n[0];
  assign exp_n   = prod.exp_sum + {9'b0, norm_hi};

  always_comb begin
    case (prod.mode)
      rm_even:  round_up = guard && (sticky || lsb);
      rm_plus:  round_up = !prod.sign && (guard || sticky);
      rm_minus: round_up = prod.sign && (guard || sticky);
      default:  round_up = 1'b0;
    endcase
  end

  assign sig_r = {1'b0, sig_n} + {{(man_w+1){1'b0}}, round_up};
  // carry out only from all ones where the fraction wraps to zero
  assign carry  = sig_r[man_w+1];
  assign frac_r = sig_r[man_w-1:0];
  assign exp_r  = exp_n + {9'b0, carry};

  assign ovf = (exp_r >= 10'sd255);
  assign unf = (exp_r <= 10'sd0);

  always_comb begin
    case (prod.mode)
      rm_even:  ovf_to_inf = 1'b1;
      rm_plus:  ovf_to_inf = !prod.sign;
      rm_minus: ovf_to_inf = prod.sign;
      default:  ovf_to_inf = 1'b0;
    endcase
  end

  always_comb begin
    flags_d = '0;
    if (prod.is_special) begin
      result_d        = prod.special_result;
      flags_d.invalid = prod.special_invalid;
    end else if (ovf) begin
      // infinity or largest finite value
      result_d = ovf_to_inf ? {prod.sign, {exp_w{1'b1}}, {man_w{1'b0}}}
                            : {prod.sign, {(exp_w-1){1'b1}}, 1'b0, {man_w{1'b1}}};
      flags_d.overflow = 1'b1;
      flags_d.inexact  = 1'b1;
    end else if (unf) begin
      // flush to signed zero
      result_d          = {prod.sign, {exp_w{1'b0}}, {man_w{1'b0}}};
      flags_d.underflow = 1'b1;
      flags_d.inexact   = 1'b1;
    end else begin
      result_d        = {prod.sign, exp_r[exp_w-1:0], frac_r};
      flags_d.inexact = guard || sticky;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
      flags     <= '0;
    end else begin
      out_valid <= prod_valid;
      if (prod_valid) begin
        result <= result_d;
        flags  <= flags_d;
      end
    end
  end

  // NaN results only come from the special path of stage one
  a_no_stray_nan: assert property (@(posedge clk) disable iff (!rst_n)
    prod_valid && !prod.is_special |=> !((&result.exp) && (result.frac != '0)));

endmodule

/* src/fp_mul_top.sv */
`timescale 1ns/1ns

module fp_mul_top
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  fp_word_t    a,
  input  fp_word_t    b,
  input  round_mode_t mode,
  output logic        out_valid,
  output fp_word_t    result,
  output fp_flags_t   flags
);

  logic        cls_valid;
  classified_t cls;
  logic        prod_valid;
  product_t    prod;

  // stage 1, classify and add exponents
  fp_operand_classify u_classify (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .mode      (mode),
    .cls_valid (cls_valid),
    .cls       (cls)
  );

  // stage 2, significand product
  fp_mant_multiply u_multiply (
    .clk        (clk),
    .rst_n      (rst_n),
    .cls_valid  (cls_valid),
    .cls        (cls),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  // stage 3, round and pack
  fp_round_pack u_round (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_valid (prod_valid),
    .prod       (prod),
    .out_valid  (out_valid),
    .result     (result),
    .flags      (flags)
  );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // synchronous reset, low for eight rising edges
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* verification/fp_mul_model.svh */
`ifndef FP_MUL_MODEL_SVH
`define FP_MUL_MODEL_SVH

typedef struct packed {
  fp_word_t  result;
  fp_flags_t flags;
} expected_t;

// one entry per accepted operand pair, oldest first
expected_t exp_q[$];

function automatic expected_t model_mul(input fp_word_t a, input fp_word_t b,
                                        input round_mode_t mode);
  expected_t   e;
  logic        s, za, zb, ia, ib, na, nb, sa, sb, up;
  logic [47:0] p, rem, half;
  logic [24:0] mant;
  int          shift;
  int          ex;
  e  = '0;
  s  = a.sign ^ b.sign;
  za = (a.exp == '0);
  zb = (b.exp == '0);
  ia = (a.exp == '1) && (a.frac == '0);
  ib = (b.exp == '1) && (b.frac == '0);
  na = (a.exp == '1) && (a.frac != '0);
  nb = (b.exp == '1) && (b.frac != '0);
  sa = na && !a.frac[man_w-1];
  sb = nb && !b.frac[man_w-1];
  if (sa || sb || (ia && zb) || (za && ib)) begin
    e.result        = canonical_nan;
    e.flags.invalid = 1'b1;
  end else if (na || nb) begin
    e.result = canonical_nan;
  end else if (ia || ib) begin
    e.result = {s, 8'hff, 23'h0};
  end else if (za || zb) begin
    e.result = {s, 31'h0};
  end else begin
    // exact product, then keep 24 bits and compare the rest with one half ulp
    p     = 48'({1'b1, a.frac}) * 48'({1'b1, b.frac});
    shift = p[47] ? 24 : 23;
    ex    = int'(a.exp) + int'(b.exp) - bias + (shift - 23);
    mant  = 25'(p >> shift);
    half  = 48'(1) << (shift - 1);
    rem   = p & ((48'(1) << shift) - 48'(1));
    case (mode)
      rm_even:  up = (rem > half) || ((rem == half) && mant[0]);
      rm_plus:  up = !s && (rem != '0);
      rm_minus: up = s && (rem != '0);
      default:  up = 1'b0;
    endcase
    mant = mant + 25'(up);
    if (mant[24]) begin
      mant = mant >> 1;
      ex   = ex + 1;
    end
    if (ex >= 255) begin
      if ((mode == rm_even) || (mode == rm_plus && !s) || (mode == rm_minus && s))
        e.result = {s, 8'hff, 23'h0};
      else
        e.result = {s, 8'hfe, 23'h7fffff};
      e.flags.overflow = 1'b1;
      e.flags.inexact  = 1'b1;
    end else if (ex <= 0) begin
      e.result          = {s, 31'h0};
      e.flags.underflow = 1'b1;
      e.flags.inexact   = 1'b1;
    end else begin
      e.result        = {s, 8'(ex), mant[22:0]};
      e.flags.inexact = (rem != '0);
    end
  end
  return e;
endfunction

`endif

/* verification/tb_fp_mul.sv */
`timescale 1ns/1ns

module tb_fp_mul
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
();

  localparam int n_directed = 12;

  logic        clk, rst_n, in_valid, out_valid, edge_seen;
  fp_word_t    a, b, result;
  round_mode_t mode;
  fp_flags_t   flags;
  integer      seed;
  logic [2:0]  valid_hist;
  // {a, b} pairs covering exact, two ties, overflow, flush, subnormal and special operands
  logic [63:0] directed [0:n_directed-1] = '{
    64'h3f800000_3f800000, 64'h3f800001_3fc00000, 64'h3f800003_3fc00000,
    64'h7f000000_40000000, 64'hff7fffff_7f7fffff, 64'h00800000_3f000000,
    64'h00000001_3f800000, 64'h7f800000_00000000, 64'h7f800001_3f800000,
    64'hffc00001_40000000, 64'hff800000_40000000, 64'h80000000_40400000};

  `include "fp_mul_model.svh"

  tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

  fp_mul_top u_fp_mul_top (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b), .mode(mode),
    .out_valid(out_valid), .result(result), .flags(flags)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input fp_word_t act, input fp_word_t exp);
    if (act !== exp)
      abort_run($sformatf("error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, act, exp));
  endtask

  task automatic check_flags(input string name, input fp_flags_t act, input fp_flags_t exp);
    if (act !== exp)
      abort_run($sformatf("error at %0t ns: %s = %b, expected %b", $time, name, act, exp));
  endtask

  task automatic check_valid(input string name, input logic act, input logic exp);
    if (act !== exp)
      abort_run($sformatf("error at %0t ns: %s = %b, expected %b", $time, name, act, exp));
  endtask

  // exponents lean toward both ends so overflow and flush show up often
  function automatic fp_word_t random_operand();
    fp_word_t    w;
    logic [31:0] r, k;
    r = $random(seed);
    k = $random(seed);
    w = r;
    case (k[3:0])
      4'd0:    w = {r[31], 31'h0};
      4'd1:    w.exp = '0;
      4'd2:    w = {r[31], 8'hff, 23'h0};
      4'd3:    w = {r[31], 8'hff, 1'b1, r[21:0]};
      4'd4:    w = {r[31], 8'hff, 1'b0, r[21:1], 1'b1};
      4'd5, 4'd6, 4'd7:  w.exp = 8'(1 + k[7:4] * 2);
      4'd8, 4'd9, 4'd10: w.exp = 8'(254 - k[7:4] * 2);
      default: w.exp = 8'(112 + k[7:4] * 2);
    endcase
    return w;
  endfunction

  task automatic drive_op(input logic valid, input fp_word_t op_a, input fp_word_t op_b,
                          input round_mode_t op_mode);
    @(posedge clk);
    in_valid <= valid;
    a        <= op_a;
    b        <= op_b;
    mode     <= op_mode;
    if (valid)
      exp_q.push_back(model_mul(op_a, op_b, op_mode));
  endtask

  always @(posedge clk) begin
    edge_seen <= 1'b1;
  end

  // out_valid must follow in_valid by exactly three edges
  always @(negedge clk) begin
    expected_t entry;
    if (edge_seen) begin
      check_valid("out_valid", out_valid, valid_hist[2]);
      if (out_valid && exp_q.size() == 0) begin
        abort_run("out_valid was high while no result was expected");
      end else if (out_valid) begin
        entry = exp_q.pop_front();
        check_word("result", result, entry.result);
        check_flags("flags", flags, entry.flags);
      end
      valid_hist <= {valid_hist[1:0], rst_n && in_valid};
    end
  end

  initial begin
    int          wait_cnt;
    logic [31:0] r;
    seed       = 32'h6ef0_3eae;
    in_valid   = 1'b0;
    a          = '0;
    b          = '0;
    mode       = rm_even;
    valid_hist = '0;
    edge_seen  = 1'b0;
    wait_cnt   = 0;
    while (rst_n !== 1'b1) begin
      if (wait_cnt > 20)
        abort_run("reset was never released");
      @(posedge clk);
      wait_cnt++;
    end
    check_word("result", result, '0);
    check_flags("flags", flags, '0);
    for (int i = 0; i < n_directed; i++) begin
      for (int m = 0; m < 4; m++)
        drive_op(1'b1, directed[i][63:32], directed[i][31:0], round_mode_t'(m));
    end
    for (int i = 0; i < 3000; i++) begin
      r = $random(seed);
      drive_op(r[1:0] != 2'b00, random_operand(), random_operand(), r[5:4]);
    end
    drive_op(1'b0, '0, '0, rm_zero);
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 10) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      abort_run("results were still missing when the drain timeout ran out");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* tb.f */
+incdir+verification
src/fp_ctrl_pkg.sv
src/fp_format_pkg.sv
src/fp_operand_classify.sv
src/fp_mant_multiply.sv
src/fp_round_pack.sv
src/fp_mul_top.sv
verification/tb_clock_gen.sv
verification/tb_fp_mul.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fp_mul
FILELIST  ?= tb.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(MDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
